// File: zx_pkg.sv
// ZX Spectrum host glue package with shared types, bank numbers and turbo codes
`default_nettype none

package zx_pkg;

	// ====================
	// Bus and memory types
	// ====================

	// Z80 address and data
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// Flat memory address, bank in the top 4 bits, 16 KB offset below
	typedef logic [17:0] mem_addr_t;
	typedef logic [3:0]  bank_t;

	// ROM images live above the eight RAM banks
	localparam bank_t BANK_ROM128 = 4'd8;
	localparam bank_t BANK_ROM48  = 4'd9;

	// Fixed RAM banks at 4000 and 8000
	localparam bank_t BANK_Q1 = 4'd5;
	localparam bank_t BANK_Q2 = 4'd2;

	// ====================
	// Clock rates
	// ====================

	// Mask applied to the clock counter, fewer ones give a faster CPU
	typedef logic [4:0] turbo_t;

	localparam turbo_t TURBO_X1  = 5'b11111;
	localparam turbo_t TURBO_X2  = 5'b01111;
	localparam turbo_t TURBO_X4  = 5'b00111;
	localparam turbo_t TURBO_X8  = 5'b00011;
	localparam turbo_t TURBO_X16 = 5'b00001;

	// ====================
	// Port decodes
	// ====================

	// Bit positions in the 7FFD byte
	localparam int PAGE_BIT_SCR  = 3;
	localparam int PAGE_BIT_ROM  = 4;
	localparam int PAGE_BIT_LOCK = 5;

	// ULA side
	typedef logic [2:0] border_t;
	typedef logic [4:0] krow_t;

endpackage

`default_nettype wire

// File: zx_cpu_bus_if.sv
// Z80 bus as seen by the paging and ULA port logic
`default_nettype none

interface zx_cpu_bus_if;

	// Address and write data from the CPU
	zx_pkg::addr_t addr;
	zx_pkg::byte_t dout;

	// Active-low strobes
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;

	// Memory paging, 7FFD decode and memory strobes
	modport pager (
		input addr, dout, mreq_n, iorq_n, rd_n, wr_n, m1_n
	);

	// Port FE and read-data return
	modport ula (
		input addr, dout, mreq_n, iorq_n, rd_n, wr_n, m1_n
	);

endinterface

`default_nettype wire

// File: zx_clock_gen.sv
// CPU clock-enable generator with turbo rates, pause and memory-wait stall
`default_nettype none

module zx_clock_gen (
	input  logic            clk_sys,
	input  logic            reset,
	input  zx_pkg::turbo_t  turbo_sel,
	input  logic            pause_req,
	input  logic            ram_ready,
	output logic            ce_cpu_p,
	output logic            ce_cpu_n
);

	logic [5:0]     counter;
	zx_pkg::turbo_t turbo;
	logic           tick_p;
	logic           tick_n;
	logic [1:0]     timeout;
	logic           cpu_en;

	// ====================
	// Tick generation
	// ====================

	// Free-running divider, masked by the active rate
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
		end else begin
			counter <= counter + 6'd1;
		end
	end

	// tick_n sits half a CPU period after tick_p
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tick_p <= 1'b0;
			tick_n <= 1'b0;
		end else begin
			tick_p <= ((counter[4:0] & turbo) == 5'b00000);
			tick_n <= ((counter[4:0] & turbo) == (turbo ^ {1'b0, turbo[4:1]}));
		end
	end

	// ====================
	// CPU enable
	// ====================

	// All decisions are taken on tick_n so the CPU never sees a short phase
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo   <= zx_pkg::TURBO_X1;
			timeout <= 2'd0;
			cpu_en  <= 1'b0;
		end else if (tick_n) begin
			// Settle counter runs 1..3 then wraps back to idle
			if (timeout != 2'd0) begin
				timeout <= timeout + 2'd1;
			end

			if (turbo != turbo_sel) begin
				// Rate change, hold the CPU while the new rate settles
				cpu_en  <= 1'b0;
				timeout <= 2'd1;
				turbo   <= turbo_sel;
			end else if (!cpu_en && timeout == 2'd0 && ram_ready) begin
				cpu_en <= ~pause_req;
			end else if (turbo[4:2] == 3'b000 && !ram_ready) begin
				// Memory too slow at X8 and X16
				cpu_en <= 1'b0;
			end else if (cpu_en && pause_req) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & tick_p;
	assign ce_cpu_n = cpu_en & tick_n;

endmodule

`default_nettype wire

// File: zx_mem_pager.sv
// 128K/48K memory paging through port 7FFD, mapped onto a flat memory address
`default_nettype none

module zx_mem_pager (
	input  logic                clk_sys,
	input  logic                reset,
	zx_cpu_bus_if.pager         bus,
	input  logic                model_48,
	output zx_pkg::mem_addr_t   mem_addr,
	output logic                mem_we,
	output logic                mem_rd,
	output logic                page_scr
);

	logic [5:0]      page_reg;
	logic            zx48;
	logic            io_wr;
	logic            io_wr_d;
	logic            page_write;
	logic            rom48_sel;
	zx_pkg::bank_t   bank;

	// ====================
	// Port 7FFD
	// ====================

	// I/O write outside interrupt acknowledge
	assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;

	// Partial decode, A15 and A1 low
	// Locked until reset once bit 5 is set, never open in 48K mode
	assign page_write = ~bus.addr[15] & ~bus.addr[1]
		& ~page_reg[zx_pkg::PAGE_BIT_LOCK] & ~zx48;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d  <= 1'b0;
			page_reg <= '0;
			// Machine model follows the input while reset is held
			zx48     <= model_48;
		end else begin
			io_wr_d <= io_wr;
			// One update per I/O cycle, on its leading edge
			if (io_wr && !io_wr_d && page_write) begin
				page_reg <= bus.dout[5:0];
			end
		end
	end

	assign page_scr = page_reg[zx_pkg::PAGE_BIT_SCR];

	// ====================
	// Address mapping
	// ====================

	assign rom48_sel = zx48 | page_reg[zx_pkg::PAGE_BIT_ROM];

	always_comb begin
		case (bus.addr[15:14])
			2'b00: begin
				if (rom48_sel) begin
					bank = zx_pkg::BANK_ROM48;
				end else begin
					bank = zx_pkg::BANK_ROM128;
				end
			end
			2'b01: bank = zx_pkg::BANK_Q1;
			2'b10: bank = zx_pkg::BANK_Q2;
			default: bank = {1'b0, page_reg[2:0]};
		endcase
	end

	assign mem_addr = {bank, bus.addr[13:0]};

	// Memory strobes, ROM quadrant is read-only
	assign mem_rd = ~bus.mreq_n & ~bus.rd_n;
	assign mem_we = ~bus.mreq_n & ~bus.wr_n & (bus.addr[15:14] != 2'b00);

endmodule

`default_nettype wire

// File: zx_ula_io.sv
// ULA port FE register and the CPU read-data return mux
`default_nettype none

module zx_ula_io (
	input  logic              clk_sys,
	input  logic              reset,
	zx_cpu_bus_if.ula         bus,
	input  zx_pkg::krow_t     key_data,
	input  logic              tape_in,
	input  zx_pkg::byte_t     ram_dout,
	output zx_pkg::border_t   border,
	output logic              ear_out,
	output logic              mic_out,
	output zx_pkg::byte_t     cpu_din
);

	logic io_wr;
	logic io_rd;
	logic io_wr_d;

	assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;
	assign io_rd = ~bus.iorq_n & ~bus.rd_n & bus.m1_n;

	// ====================
	// Port FE write
	// ====================

	// Any even port reaches the ULA
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			if (io_wr && !io_wr_d && !bus.addr[0]) begin
				border  <= bus.dout[2:0];
				ear_out <= bus.dout[4];
				mic_out <= bus.dout[3];
			end
		end
	end

	// ====================
	// Read data return
	// ====================

	always_comb begin
		if (!bus.mreq_n) begin
			cpu_din = ram_dout;
		end else if (io_rd && !bus.addr[0]) begin
			// Tape input reads back inverted on bit 6
			cpu_din = {1'b1, ~tape_in, 1'b1, key_data};
		end else begin
			// Floating bus
			cpu_din = 8'hFF;
		end
	end

endmodule

`default_nettype wire

// File: zx_beeper_dac.sv
// First-order sigma-delta DAC mixing ear, mic and tape input into one bit
`default_nettype none

module zx_beeper_dac #(
	parameter int DAC_WIDTH = 8
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ear_out,
	input  logic mic_out,
	input  logic tape_in,
	output logic audio_out
);

	logic [DAC_WIDTH-1:0] level;
	logic [DAC_WIDTH-1:0] acc;
	logic [DAC_WIDTH:0]   sum;

	// Ear is loudest, then mic, then tape
	assign level = DAC_WIDTH'({ear_out, mic_out, tape_in}) << (DAC_WIDTH - 3);

	// Carry out of the accumulator is the output bit
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[DAC_WIDTH-1:0];
			audio_out <= sum[DAC_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: zx_host_core.sv
// ZX Spectrum 128K host glue top level joining clock, paging, ULA port and DAC
`default_nettype none

module zx_host_core #(
	parameter int DAC_WIDTH = 8
) (
	input  logic              clk_sys,
	input  logic              reset,
	// Z80 bus
	input  zx_pkg::addr_t     addr,
	input  zx_pkg::byte_t     dout,
	input  logic              mreq_n,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	// Control and external inputs
	input  zx_pkg::turbo_t    turbo_sel,
	input  logic              pause_req,
	input  logic              ram_ready,
	input  logic              model_48,
	input  zx_pkg::krow_t     key_data,
	input  logic              tape_in,
	input  zx_pkg::byte_t     ram_dout,
	// Outputs
	output logic              ce_cpu_p,
	output logic              ce_cpu_n,
	output zx_pkg::mem_addr_t mem_addr,
	output logic              mem_we,
	output logic              mem_rd,
	output logic              page_scr,
	output zx_pkg::border_t   border,
	output logic              ear_out,
	output logic              mic_out,
	output zx_pkg::byte_t     cpu_din,
	output logic              audio_out
);

	zx_cpu_bus_if bus ();

	assign bus.addr   = addr;
	assign bus.dout   = dout;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	zx_clock_gen u_clock_gen (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.turbo_sel (turbo_sel),
		.pause_req (pause_req),
		.ram_ready (ram_ready),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n)
	);

	zx_mem_pager u_mem_pager (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus.pager),
		.model_48 (model_48),
		.mem_addr (mem_addr),
		.mem_we   (mem_we),
		.mem_rd   (mem_rd),
		.page_scr (page_scr)
	);

	zx_ula_io u_ula_io (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus.ula),
		.key_data (key_data),
		.tape_in  (tape_in),
		.ram_dout (ram_dout),
		.border   (border),
		.ear_out  (ear_out),
		.mic_out  (mic_out),
		.cpu_din  (cpu_din)
	);

	zx_beeper_dac #(
		.DAC_WIDTH (DAC_WIDTH)
	) u_beeper_dac (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ear_out   (ear_out),
		.mic_out   (mic_out),
		.tape_in   (tape_in),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

// File: zx_host_chk.sv
// Bound assertions on the ZX host glue top level
`default_nettype none

module zx_host_chk (
	input  wire logic          clk_sys,
	input  wire logic          reset,
	input  wire logic          ce_cpu_p,
	input  wire logic          ce_cpu_n,
	input  wire logic          mem_we,
	input  wire zx_pkg::addr_t addr,
	input  wire logic          ear_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// Number of failed assertions
	int unsigned fail_count = 0;

	// The two CPU phases never coincide
	ce_phase: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n))
		else begin
			$error("ce_cpu_p and ce_cpu_n high together");
			fail_count++;
		end

	// ROM quadrant is never written
	rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && addr[15:14] == 2'b00))
		else begin
			$error("mem_we raised in the ROM quadrant");
			fail_count++;
		end

	// Speaker starts silent
	ear_reset: assert property (@(posedge clk_sys) $fell(reset) |-> !ear_out)
		else begin
			$error("ear_out high right after reset");
			fail_count++;
		end

endmodule

bind zx_host_core zx_host_chk u_chk (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.ce_cpu_p (ce_cpu_p),
	.ce_cpu_n (ce_cpu_n),
	.mem_we   (mem_we),
	.addr     (addr),
	.ear_out  (ear_out)
);

`default_nettype wire

// File: tb_zx_host.sv
// Testbench for the ZX Spectrum host glue with reference models and timeout
`default_nettype none

module tb_zx_host;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TEST_CYCLES = 13000;
	localparam int LIMIT       = TEST_CYCLES * 3 / 2;

	localparam int K_ADDR   = 0;
	localparam int K_DIN    = 1;
	localparam int K_BORDER = 2;
	localparam int K_SCR    = 3;
	localparam int K_EAR    = 4;
	localparam int K_MIC    = 5;
	localparam int K_WE     = 6;
	localparam int K_RD     = 7;
	localparam int K_CNT    = 8;

	typedef struct {
		int          kind;
		logic [17:0] exp_v;
		int          act_v;
		string       name;
	} exp_t;

	logic clk_sys = 1'b0;
	logic reset;
	zx_pkg::addr_t addr;
	zx_pkg::byte_t dout;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n;
	zx_pkg::turbo_t turbo_sel;
	logic pause_req, ram_ready, model_48, tape_in;
	zx_pkg::krow_t key_data;
	zx_pkg::byte_t ram_dout;
	logic ce_cpu_p, ce_cpu_n, mem_we, mem_rd, page_scr, ear_out, mic_out, audio_out;
	zx_pkg::mem_addr_t mem_addr;
	zx_pkg::border_t border;
	zx_pkg::byte_t cpu_din;

	// Reference state
	logic [5:0] page_m;
	logic zx48_m, ear_m, mic_m;
	zx_pkg::border_t border_m;

	exp_t exp_q[$];
	exp_t cur;
	int cycle = 0;

	zx_host_core #(.DAC_WIDTH(8)) dut (.*);

	always #4 clk_sys = ~clk_sys;

	// ====================
	// Reference models
	// ====================

	function automatic logic [5:0] page_next(logic [5:0] pg, zx_pkg::addr_t a,
		zx_pkg::byte_t d, logic m48);
		if (!a[15] && !a[1] && !pg[5] && !m48)
			return d[5:0];
		return pg;
	endfunction

	function automatic zx_pkg::mem_addr_t map_addr(zx_pkg::addr_t a, logic [5:0] pg,
		logic m48);
		zx_pkg::bank_t b;
		case (a[15:14])
			2'b00: b = (m48 || pg[4]) ? zx_pkg::BANK_ROM48 : zx_pkg::BANK_ROM128;
			2'b01: b = zx_pkg::BANK_Q1;
			2'b10: b = zx_pkg::BANK_Q2;
			default: b = {1'b0, pg[2:0]};
		endcase
		return {b, a[13:0]};
	endfunction

	function automatic zx_pkg::byte_t fe_byte(zx_pkg::krow_t k, logic t);
		return {1'b1, ~t, 1'b1, k};
	endfunction

	// Level for an 8-bit accumulator
	function automatic int dac_level(logic e, logic m, logic t);
		return e * 128 + m * 64 + t * 32;
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic fail_run(input string why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic value_error(input string name, input string e, input string a);
		$display("Error: time %0t signal %s expected %s actual %s", $time, name, e, a);
		fail_run("output value mismatch");
	endtask

	task automatic check_addr(input zx_pkg::mem_addr_t e, a, input string name);
		if (e !== a)
			value_error(name, $sformatf("%h", e), $sformatf("%h", a));
	endtask

	task automatic check_byte(input zx_pkg::byte_t e, a, input string name);
		if (e !== a)
			value_error(name, $sformatf("%h", e), $sformatf("%h", a));
	endtask

	task automatic check_border(input zx_pkg::border_t e, a, input string name);
		if (e !== a)
			value_error(name, $sformatf("%0d", e), $sformatf("%0d", a));
	endtask

	task automatic check_bit(input logic e, a, input string name);
		if (e !== a)
			value_error(name, $sformatf("%b", e), $sformatf("%b", a));
	endtask

	task automatic check_count(input int e, a, input string name);
		if (e != a)
			value_error(name, $sformatf("%0d", e), $sformatf("%0d", a));
	endtask

	task automatic expect_val(input int k, input logic [17:0] v, input string n,
		input int act = 0);
		exp_t e;
		e.kind = k;
		e.exp_v = v;
		e.act_v = act;
		e.name = n;
		exp_q.push_back(e);
	endtask

	// Inputs change on the falling edge, so outputs are settled shortly after the rise
	always begin
		@(posedge clk_sys);
		#2;
		while (exp_q.size() > 0) begin
			cur = exp_q.pop_front();
			case (cur.kind)
				K_ADDR:   check_addr(cur.exp_v, mem_addr, cur.name);
				K_DIN:    check_byte(cur.exp_v[7:0], cpu_din, cur.name);
				K_BORDER: check_border(cur.exp_v[2:0], border, cur.name);
				K_SCR:    check_bit(cur.exp_v[0], page_scr, cur.name);
				K_EAR:    check_bit(cur.exp_v[0], ear_out, cur.name);
				K_MIC:    check_bit(cur.exp_v[0], mic_out, cur.name);
				K_WE:     check_bit(cur.exp_v[0], mem_we, cur.name);
				K_RD:     check_bit(cur.exp_v[0], mem_rd, cur.name);
				default:  check_count(int'(cur.exp_v), cur.act_v, cur.name);
			endcase
		end
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (dut.u_chk.fail_count != 0)
			fail_run("a bound assertion on the DUT failed");
		if (cycle >= LIMIT)
			fail_run("timeout, the test did not finish within the cycle limit");
	end

	// ====================
	// Bus cycles
	// ====================

	task automatic bus_idle();
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic do_reset(input logic m48);
		@(negedge clk_sys);
		reset = 1'b1;
		model_48 = m48;
		bus_idle();
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		page_m = '0;
		zx48_m = m48;
		border_m = '0;
		ear_m = 1'b0;
		mic_m = 1'b0;
		expect_val(K_SCR, 0, "page_scr");
	endtask

	task automatic mem_read(input zx_pkg::addr_t a);
		zx_pkg::byte_t rd;
		@(negedge clk_sys);
		rd = $urandom;
		addr = a;
		ram_dout = rd;
		mreq_n = 1'b0;
		rd_n = 1'b0;
		expect_val(K_ADDR, map_addr(a, page_m, zx48_m), "mem_addr");
		expect_val(K_DIN, rd, "cpu_din");
		expect_val(K_RD, 1, "mem_rd");
		expect_val(K_WE, 0, "mem_we");
		repeat (2) @(negedge clk_sys);
		bus_idle();
	endtask

	task automatic mem_write(input zx_pkg::addr_t a);
		@(negedge clk_sys);
		addr = a;
		dout = $urandom;
		mreq_n = 1'b0;
		wr_n = 1'b0;
		expect_val(K_WE, a >= 16'h4000, "mem_we");
		expect_val(K_ADDR, map_addr(a, page_m, zx48_m), "mem_addr");
		repeat (2) @(negedge clk_sys);
		bus_idle();
	endtask

	task automatic io_write(input zx_pkg::addr_t a, input zx_pkg::byte_t d);
		@(negedge clk_sys);
		addr = a;
		dout = d;
		iorq_n = 1'b0;
		wr_n = 1'b0;
		repeat (3) @(negedge clk_sys);
		bus_idle();
		page_m = page_next(page_m, a, d, zx48_m);
		if (!a[0]) begin
			border_m = d[2:0];
			ear_m = d[4];
			mic_m = d[3];
		end
		expect_val(K_SCR, page_m[3], "page_scr");
		expect_val(K_BORDER, border_m, "border");
		expect_val(K_EAR, ear_m, "ear_out");
		expect_val(K_MIC, mic_m, "mic_out");
	endtask

	task automatic io_read(input zx_pkg::addr_t a);
		@(negedge clk_sys);
		key_data = $urandom;
		tape_in = $urandom;
		addr = a;
		iorq_n = 1'b0;
		rd_n = 1'b0;
		expect_val(K_DIN, a[0] ? 8'hFF : fe_byte(key_data, tape_in), "cpu_din");
		expect_val(K_RD, 0, "mem_rd");
		repeat (2) @(negedge clk_sys);
		bus_idle();
	endtask

	task automatic paging_round(input bit no_lock);
		zx_pkg::addr_t a;
		zx_pkg::byte_t d;
		a = $urandom;
		a[15] = ($urandom % 4) == 0;
		d = $urandom;
		if (no_lock)
			d[5] = 1'b0;
		io_write(a, d);
		mem_read({2'b11, 14'($urandom)});
		mem_read({2'b00, 14'($urandom)});
		mem_write({2'b00, 14'($urandom)});
		mem_write({2'($urandom), 14'($urandom)});
	endtask

	// ====================
	// Clock enables
	// ====================

	task automatic wait_pulse(input logic phase_n, output int t);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!(phase_n ? ce_cpu_n : ce_cpu_p)) begin
			n++;
			if (n > 300)
				fail_run("no clock-enable pulse within 300 cycles");
			@(negedge clk_sys);
		end
		t = cycle;
	endtask

	task automatic measure_rate(input zx_pkg::turbo_t code, input int period);
		int t1;
		int t2;
		int t3;
		@(negedge clk_sys);
		turbo_sel = code;
		// First pulse may still belong to the old rate
		wait_pulse(1'b0, t1);
		wait_pulse(1'b0, t1);
		wait_pulse(1'b0, t2);
		wait_pulse(1'b1, t3);
		expect_val(K_CNT, period, "ce_cpu_p spacing", t2 - t1);
		expect_val(K_CNT, period / 2, "ce_cpu_n offset", t3 - t2);
	endtask

	initial begin
		zx_pkg::turbo_t codes[5];
		int periods[5];
		int cnt;

		void'($urandom(32'h2bbc));
		reset = 1'b1;
		addr = '0;
		dout = '0;
		bus_idle();
		turbo_sel = zx_pkg::TURBO_X1;
		pause_req = 1'b0;
		ram_ready = 1'b1;
		model_48 = 1'b0;
		key_data = '1;
		tape_in = 1'b0;
		ram_dout = '0;
		codes = '{zx_pkg::TURBO_X1, zx_pkg::TURBO_X2, zx_pkg::TURBO_X4,
			zx_pkg::TURBO_X8, zx_pkg::TURBO_X16};
		periods = '{32, 16, 8, 4, 2};

		// Reset mapping in both models
		for (int m = 0; m < 2; m++) begin
			do_reset(m[0]);
			for (int q = 0; q < 4; q++)
				mem_read({q[1:0], 14'($urandom)});
		end

		// Paging, then lock, then 48K mode
		do_reset(1'b0);
		repeat (30) paging_round(1'b1);
		io_write(16'h7FFD, 8'h27);
		repeat (10) paging_round(1'b0);
		do_reset(1'b1);
		repeat (6) paging_round(1'b0);

		// Port FE
		do_reset(1'b0);
		repeat (20) begin
			io_write({16'($urandom)} | 16'h8000, $urandom);
			io_read({15'($urandom), 1'b0});
			io_read({15'($urandom), 1'b1});
			mem_read($urandom);
		end

		// Turbo rates and pause
		for (int i = 0; i < 5; i++)
			measure_rate(codes[i], periods[i]);
		@(negedge clk_sys);
		pause_req = 1'b1;
		repeat (70) @(negedge clk_sys);
		cnt = 0;
		repeat (100) begin
			@(negedge clk_sys);
			cnt += ce_cpu_p;
		end
		expect_val(K_CNT, 0, "ce_cpu_p during pause", cnt);
		pause_req = 1'b0;

		// Beeper DAC
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			tape_in = i[0];
			io_write(16'hFFFE, {3'b000, i[2], i[1], 3'b000});
			repeat (3) @(negedge clk_sys);
			cnt = 0;
			repeat (256) begin
				@(negedge clk_sys);
				cnt += audio_out;
			end
			expect_val(K_CNT, dac_level(i[2], i[1], i[0]), "audio_out count", cnt);
		end

		repeat (4) @(negedge clk_sys);
		if (exp_q.size() == 0 && dut.u_chk.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			fail_run("expected values were left unchecked or a bound assertion failed");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
zx_pkg.sv
zx_cpu_bus_if.sv
zx_clock_gen.sv
zx_mem_pager.sv
zx_ula_io.sv
zx_beeper_dac.sv
zx_host_core.sv
zx_host_chk.sv
tb_zx_host.sv
